/* cp0_tlb_top.f */
logic/cp0_pkg.sv
logic/tlb_pkg.sv
logic/cp0_commit.sv
logic/cp0_regs.sv
logic/tlb_array.sv
logic/cp0_tlb_top.sv
test/cp0_tlb_top_asserts.sv
test/cp0_tlb_top_tb.sv

/* Bender.yml */
package:
  name: cp0_tlb

sources:
  - logic/cp0_pkg.sv
  - logic/tlb_pkg.sv
  - logic/cp0_commit.sv
  - logic/cp0_regs.sv
  - logic/tlb_array.sv
  - logic/cp0_tlb_top.sv
  - target: test
    files:
      - test/cp0_tlb_top_asserts.sv
      - test/cp0_tlb_top_tb.sv

/* test/cp0_tlb_top_tb.sv */
`timescale 1ns/10ps

module cp0_tlb_top_tb;

    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int TLB_ENTRIES  = 16;
    localparam int IDX_W        = $clog2(TLB_ENTRIES);
    localparam int RESET_CYCLES = 5;
    localparam int MAX_COMMITS  = 160;   // About 115 commits over all tests, two cycles each
    localparam int TIMER_WAIT   = 64;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * MAX_COMMITS + TIMER_WAIT + 40;

    logic       clk = 1'b0;
    logic       reset;
    logic       valid;
    commit_op_t op;
    logic [4:0] rd;
    logic [2:0] sel;
    word_t      wdata;
    logic       ex;
    exc_code_t  exc_code;
    word_t      pc;
    logic       bd;
    word_t      bad_vaddr;
    logic [5:0] ext_int;
    word_t      rdata;
    logic       flush;
    word_t      flush_pc;
    logic       eret_flush;
    logic       exc_flush;
    logic       timer_int;

    logic [31:0] lfsr = 32'h9c6550b0;
    int          errors;
    int          checks;
    int          test_errors;
    int          cycle_count;
    string       test_name;
    logic        got_flush, got_eret, got_exc;   // Sampled mid-cycle of the last commit
    word_t       got_pc, got_rdata;

    // Model of the entries written by tlbwi
    logic [IDX_W-1:0] m_idx [4];
    vpn2_t            m_vpn2 [4];
    asid_t            m_asid [4];
    logic             m_g [4];
    word_t            m_lo0 [4];
    word_t            m_lo1 [4];

    cp0_tlb_top #(.TLB_ENTRIES(TLB_ENTRIES)) i_cp0_tlb_top (.*);

    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // Drives one retiring instruction and samples the outputs at the falling edge
    task automatic issue(input commit_op_t o, input cp0_addr_t a, input word_t d,
                         input logic e, input exc_code_t code, input word_t p,
                         input logic b, input word_t bva);
        @(posedge clk);
        valid     <= 1'b1;
        op        <= o;
        {rd, sel} <= a;
        wdata     <= d;
        ex        <= e;
        exc_code  <= code;
        pc        <= p;
        bd        <= b;
        bad_vaddr <= bva;
        @(negedge clk);
        got_flush = flush;
        got_eret  = eret_flush;
        got_exc   = exc_flush;
        got_pc    = flush_pc;
        got_rdata = rdata;
        @(posedge clk);
        valid <= 1'b0;
        ex    <= 1'b0;
        op    <= OP_NONE;
    endtask

    task automatic write_cp0(input cp0_addr_t a, input word_t d);
        issue(OP_MTC0, a, d, 1'b0, EXC_INT, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic read_cp0(input cp0_addr_t a, output word_t d);
        issue(OP_MFC0, a, 32'h0, 1'b0, EXC_INT, 32'h0, 1'b0, 32'h0);
        d = got_rdata;
    endtask

    task automatic commit_op(input commit_op_t o);
        issue(o, 8'h0, 32'h0, 1'b0, EXC_INT, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic raise_exc(input exc_code_t code, input word_t p, input logic b,
                             input word_t bva);
        issue(OP_NONE, 8'h0, 32'h0, 1'b1, code, p, b, bva);
    endtask

    task automatic expect_reg(input string what, input cp0_addr_t a, input word_t expected);
        word_t v;
        read_cp0(a, v);
        check_value(what, expected, v);
    endtask

    task automatic flush_matches(input logic exc_exp, input logic eret_exp, input word_t pc_exp);
        check_value("exc_flush", exc_exp, got_exc);
        check_value("eret_flush", eret_exp, got_eret);
        check_value("flush", exc_exp | eret_exp, got_flush);
        if (exc_exp | eret_exp)
            check_value("flush_pc", pc_exp, got_pc);
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic report_test();
        $display("%-20s %s (%0d mismatches)", test_name,
                 test_errors == 0 ? "ok" : "bad", test_errors);
    endtask

    task automatic reg_round_trip();
        cp0_addr_t addrs [7] = '{EPC_ADDR, ENTRYHI_ADDR, ENTRYLO0_ADDR, ENTRYLO1_ADDR,
                                 INDEX_ADDR, COMPARE_ADDR, STATUS_ADDR};
        word_t     masks [7] = '{32'hFFFF_FFFF, 32'hFFFF_E0FF, 32'h03FF_FFFF, 32'h03FF_FFFF,
                                 (32'd1 << IDX_W) - 1, 32'hFFFF_FFFF, 32'h0000_FF03};
        word_t     w;
        open_test("reg_round_trip");
        for (int i = 0; i < 7; i++) begin
            w = next_bits(32);
            write_cp0(addrs[i], w);
            expect_reg($sformatf("addr %h", addrs[i]), addrs[i],
                       (w & masks[i]) | (addrs[i] == STATUS_ADDR ? 32'h0040_0000 : 32'h0));
        end
        expect_reg("unmapped rd 1", {5'd1, 3'd0}, 32'h0);
        expect_reg("unmapped sel 1", {5'd12, 3'd1}, 32'h0);
        write_cp0(STATUS_ADDR, 32'h0);
        report_test();
    endtask

    task automatic exception_and_eret();
        word_t p1;
        word_t p2;
        word_t v;
        open_test("exception_and_eret");
        p1 = next_bits(32) & ~32'h3;
        p2 = next_bits(32) & ~32'h3;
        raise_exc(EXC_SYS, p1, 1'b1, 32'h0);
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        expect_reg("epc in delay slot", EPC_ADDR, p1 - 32'd4);
        read_cp0(CAUSE_ADDR, v);
        check_value("cause bd", 1'b1, v[31]);
        check_value("exc code", EXC_SYS, v[6:2]);
        expect_reg("status exl set", STATUS_ADDR, 32'h0040_0002);
        raise_exc(EXC_OV, p2, 1'b0, 32'h0);   // Nested while EXL is set
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        expect_reg("epc kept", EPC_ADDR, p1 - 32'd4);
        read_cp0(CAUSE_ADDR, v);
        check_value("cause bd kept", 1'b1, v[31]);
        check_value("nested exc code", EXC_OV, v[6:2]);
        commit_op(OP_ERET);
        flush_matches(1'b0, 1'b1, p1 - 32'd4);
        expect_reg("status exl cleared", STATUS_ADDR, 32'h0040_0000);
        report_test();
    endtask

    task automatic address_error();
        word_t p;
        word_t bva;
        open_test("address_error");
        p   = (next_bits(32) & ~32'h3) | 32'h2;
        bva = next_bits(32);
        raise_exc(EXC_ADEL, p, 1'b0, bva);
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        expect_reg("badvaddr from pc", BADVADDR_ADDR, p);
        commit_op(OP_ERET);
        p   = next_bits(32) & ~32'h3;
        bva = next_bits(32);
        raise_exc(EXC_ADES, p, 1'b0, bva);
        expect_reg("badvaddr from data", BADVADDR_ADDR, bva);
        commit_op(OP_ERET);
        flush_matches(1'b0, 1'b1, p);
        report_test();
    endtask

    task automatic tlb_write_probe();
        word_t r;
        open_test("tlb_write_probe");
        for (int i = 0; i < 4; i++) begin
            r         = next_bits(14);
            m_idx[i]  = IDX_W'(i * 5 + 2);
            m_vpn2[i] = {1'b1, r[13:0], 4'(i)};     // Distinct and never zero
            m_asid[i] = asid_t'(next_bits(8));
            m_lo0[i]  = next_bits(26);
            m_lo1[i]  = next_bits(26) & ~32'h1;
            if (i == 2) begin                       // One global entry
                m_lo0[i][0] = 1'b1;
                m_lo1[i][0] = 1'b1;
            end
            m_g[i] = m_lo0[i][0] & m_lo1[i][0];
            write_cp0(ENTRYHI_ADDR, {m_vpn2[i], 5'b0, m_asid[i]});
            write_cp0(ENTRYLO0_ADDR, m_lo0[i]);
            write_cp0(ENTRYLO1_ADDR, m_lo1[i]);
            write_cp0(INDEX_ADDR, word_t'(m_idx[i]));
            commit_op(OP_TLBWI);
        end
        for (int i = 0; i < 4; i++) begin
            // Global entry hits with a foreign ASID
            write_cp0(ENTRYHI_ADDR, {m_vpn2[i], 5'b0, m_g[i] ? ~m_asid[i] : m_asid[i]});
            write_cp0(INDEX_ADDR, word_t'(m_idx[i]) ^ 32'hF);
            commit_op(OP_TLBP);
            expect_reg($sformatf("probe hit %0d", i), INDEX_ADDR, word_t'(m_idx[i]));
        end
        write_cp0(ENTRYHI_ADDR, {m_vpn2[0], 5'b0, ~m_asid[0]});
        write_cp0(INDEX_ADDR, 32'h5);
        commit_op(OP_TLBP);
        expect_reg("probe miss", INDEX_ADDR, 32'h8000_0005);
        report_test();
    endtask

    task automatic tlb_read();
        open_test("tlb_read");
        for (int i = 0; i < 4; i++) begin
            write_cp0(INDEX_ADDR, word_t'(m_idx[i]));
            commit_op(OP_TLBR);
            expect_reg("entryhi", ENTRYHI_ADDR, {m_vpn2[i], 5'b0, m_asid[i]});
            expect_reg("entrylo0", ENTRYLO0_ADDR, (m_lo0[i] & ~32'h1) | word_t'(m_g[i]));
            expect_reg("entrylo1", ENTRYLO1_ADDR, (m_lo1[i] & ~32'h1) | word_t'(m_g[i]));
        end
        report_test();
    endtask

    task automatic interrupts();
        word_t v;
        open_test("interrupts");
        write_cp0(STATUS_ADDR, 32'h0000_0101);      // IM0 and IE
        write_cp0(CAUSE_ADDR, 32'h0000_0100);
        commit_op(OP_NONE);
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        read_cp0(CAUSE_ADDR, v);
        check_value("soft exc code", EXC_INT, v[6:2]);
        write_cp0(CAUSE_ADDR, 32'h0);
        commit_op(OP_ERET);
        write_cp0(STATUS_ADDR, 32'h0000_0801);      // IM3 follows ext_int[1]
        @(posedge clk);
        ext_int <= 6'b000010;
        @(posedge clk);
        commit_op(OP_NONE);
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        @(posedge clk);
        ext_int <= 6'b0;
        repeat (2) @(posedge clk);
        commit_op(OP_ERET);
        write_cp0(STATUS_ADDR, 32'h0000_0800);      // Same line with IE clear
        @(posedge clk);
        ext_int <= 6'b000010;
        @(posedge clk);
        commit_op(OP_NONE);
        flush_matches(1'b0, 1'b0, 32'h0);
        @(posedge clk);
        ext_int <= 6'b0;
        write_cp0(STATUS_ADDR, 32'h0000_8000);
        read_cp0(COUNT_ADDR, v);
        write_cp0(COMPARE_ADDR, v + 32'd6);
        write_cp0(STATUS_ADDR, 32'h0000_8001);
        for (int n = 0; n < TIMER_WAIT && !timer_int; n++)
            @(negedge clk);
        if (!timer_int) begin
            $display("[ERROR] %s: timer interrupt not raised within %0d cycles",
                     test_name, TIMER_WAIT);
            errors++;
            test_errors++;
        end
        commit_op(OP_NONE);
        flush_matches(1'b1, 1'b0, EXC_VECTOR);
        read_cp0(CAUSE_ADDR, v);
        check_value("timer exc code", EXC_INT, v[6:2]);
        write_cp0(COMPARE_ADDR, 32'hFFFF_0000);
        read_cp0(CAUSE_ADDR, v);
        check_value("ti cleared", 1'b0, v[30]);
        check_value("timer_int low", 1'b0, timer_int);
        write_cp0(STATUS_ADDR, 32'h0);
        report_test();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        valid     = 1'b0;
        op        = OP_NONE;
        rd        = '0;
        sel       = '0;
        wdata     = '0;
        ex        = 1'b0;
        exc_code  = EXC_INT;
        pc        = '0;
        bd        = 1'b0;
        bad_vaddr = '0;
        ext_int   = '0;
        errors    = 0;
        checks    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        reg_round_trip();
        exception_and_eret();
        address_error();
        tlb_write_probe();
        tlb_read();
        interrupts();
        errors += i_cp0_tlb_top.i_cp0_commit.i_cp0_tlb_top_asserts.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* test/cp0_tlb_top_asserts.sv */
`timescale 1ns/10ps

module cp0_tlb_top_asserts (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic eret_flush,
    input logic exc_flush,
    input logic status_exl
);

    int fail_count = 0;    // Failed assertions so far

    flush_is_or: assert property (@(posedge clk) disable iff (reset)
        flush == (eret_flush || exc_flush))
        else begin
            fail_count++;
            $error("flush differs from the OR of eret_flush and exc_flush");
        end

    // Eret and an exception never retire together
    one_redirect: assert property (@(posedge clk) disable iff (reset)
        !(eret_flush && exc_flush))
        else begin
            fail_count++;
            $error("eret_flush and exc_flush are high together");
        end

    quiet_in_reset: assert property (@(posedge clk) reset |-> !flush)
        else begin
            fail_count++;
            $error("flush is high during reset");
        end

    exl_after_exc: assert property (@(posedge clk) disable iff (reset)
        exc_flush |=> status_exl)
        else begin
            fail_count++;
            $error("status_exl is not set in the cycle after exc_flush");
        end

endmodule

bind cp0_commit cp0_tlb_top_asserts i_cp0_tlb_top_asserts (
    .clk(clk),
    .reset(reset),
    .flush(flush),
    .eret_flush(eret_flush),
    .exc_flush(exc_flush),
    .status_exl(status_exl)
);

/* logic/cp0_tlb_top.sv */
`timescale 1ns/10ps

module cp0_tlb_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cp0_pkg::commit_op_t op,
    input  logic [4:0]          rd,
    input  logic [2:0]          sel,
    input  cp0_pkg::word_t      wdata,
    input  logic                ex,
    input  cp0_pkg::exc_code_t  exc_code,
    input  cp0_pkg::word_t      pc,
    input  logic                bd,
    input  cp0_pkg::word_t      bad_vaddr,
    input  logic [5:0]          ext_int,
    output cp0_pkg::word_t      rdata,
    output logic                flush,
    output cp0_pkg::word_t      flush_pc,
    output logic                eret_flush,
    output logic                exc_flush,
    output logic                timer_int
);

    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // Commit unit to register file and TLB
    logic       mtc0_we, eret, exc, tlbp, tlbr, tlbwi;
    exc_code_t  exc_code_out;
    cp0_addr_t  addr;

    // Register file state seen by the commit unit
    logic       status_ie, status_exl;
    logic [7:0] status_im, cause_ip;
    word_t      epc;

    // Entry registers toward the TLB
    vpn2_t      entryhi_vpn2;
    asid_t      entryhi_asid;
    pfn_t       lo0_pfn, lo1_pfn;
    cattr_t     lo0_c, lo1_c;
    logic       lo0_d, lo0_v, lo0_g, lo1_d, lo1_v, lo1_g;
    logic [IDX_W-1:0] index;

    // Probe and read results back from the TLB
    logic       found;
    logic [IDX_W-1:0] probe_index;
    vpn2_t      rd_vpn2;
    asid_t      rd_asid;
    logic       rd_g;
    pfn_t       rd_pfn0, rd_pfn1;
    cattr_t     rd_c0, rd_c1;
    logic       rd_d0, rd_v0, rd_d1, rd_v1;

    cp0_commit i_cp0_commit (.*);

    cp0_regs #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_cp0_regs (.*);

    tlb_array #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) i_tlb_array (.*);

endmodule

/* logic/tlb_array.sv */
`timescale 1ns/10ps

module tlb_array #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tlbwi,
    input  logic [$clog2(TLB_ENTRIES)-1:0] index,
    input  tlb_pkg::vpn2_t                 entryhi_vpn2,
    input  tlb_pkg::asid_t                 entryhi_asid,
    input  tlb_pkg::pfn_t                  lo0_pfn,
    input  tlb_pkg::cattr_t                lo0_c,
    input  logic                           lo0_d,
    input  logic                           lo0_v,
    input  logic                           lo0_g,
    input  tlb_pkg::pfn_t                  lo1_pfn,
    input  tlb_pkg::cattr_t                lo1_c,
    input  logic                           lo1_d,
    input  logic                           lo1_v,
    input  logic                           lo1_g,
    output logic                           found,
    output logic [$clog2(TLB_ENTRIES)-1:0] probe_index,
    output tlb_pkg::vpn2_t                 rd_vpn2,
    output tlb_pkg::asid_t                 rd_asid,
    output logic                           rd_g,
    output tlb_pkg::pfn_t                  rd_pfn0,
    output tlb_pkg::cattr_t                rd_c0,
    output logic                           rd_d0,
    output logic                           rd_v0,
    output tlb_pkg::pfn_t                  rd_pfn1,
    output tlb_pkg::cattr_t                rd_c1,
    output logic                           rd_d1,
    output logic                           rd_v1
);

    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    vpn2_t  tlb_vpn2 [TLB_ENTRIES];
    asid_t  tlb_asid [TLB_ENTRIES];
    logic   tlb_g    [TLB_ENTRIES];
    logic   tlb_v0   [TLB_ENTRIES];
    logic   tlb_v1   [TLB_ENTRIES];
    pfn_t   tlb_pfn0 [TLB_ENTRIES];
    cattr_t tlb_c0   [TLB_ENTRIES];
    logic   tlb_d0   [TLB_ENTRIES];
    pfn_t   tlb_pfn1 [TLB_ENTRIES];
    cattr_t tlb_c1   [TLB_ENTRIES];
    logic   tlb_d1   [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] match;

    // Reset clears the tag side and the valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                tlb_vpn2[i] <= '0;
                tlb_asid[i] <= '0;
                tlb_g[i]    <= 1'b0;
                tlb_v0[i]   <= 1'b0;
                tlb_v1[i]   <= 1'b0;
            end
        end else if (tlbwi) begin
            tlb_vpn2[index] <= entryhi_vpn2;
            tlb_asid[index] <= entryhi_asid;
            tlb_g[index]    <= lo0_g & lo1_g;   // Global only if both halves are
            tlb_v0[index]   <= lo0_v;
            tlb_v1[index]   <= lo1_v;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbwi) begin
            tlb_pfn0[index] <= lo0_pfn;
            tlb_c0[index]   <= lo0_c;
            tlb_d0[index]   <= lo0_d;
            tlb_pfn1[index] <= lo1_pfn;
            tlb_c1[index]   <= lo1_c;
            tlb_d1[index]   <= lo1_d;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = (tlb_vpn2[i] == entryhi_vpn2) &&
                       (tlb_g[i] || tlb_asid[i] == entryhi_asid);
        end
    end

    assign found = |match;

    always_comb begin
        probe_index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i])
                probe_index = IDX_W'(i);        // Lowest hit wins
        end
    end

    assign rd_vpn2 = tlb_vpn2[index];
    assign rd_asid = tlb_asid[index];
    assign rd_g    = tlb_g[index];
    assign rd_pfn0 = tlb_pfn0[index];
    assign rd_c0   = tlb_c0[index];
    assign rd_d0   = tlb_d0[index];
    assign rd_v0   = tlb_v0[index];
    assign rd_pfn1 = tlb_pfn1[index];
    assign rd_c1   = tlb_c1[index];
    assign rd_d1   = tlb_d1[index];
    assign rd_v1   = tlb_v1[index];

endmodule

/* logic/cp0_regs.sv */
`timescale 1ns/10ps

module cp0_regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mtc0_we,
    input  logic                           eret,
    input  logic                           exc,
    input  cp0_pkg::exc_code_t             exc_code_out,
    input  logic                           tlbp,
    input  logic                           tlbr,
    input  cp0_pkg::cp0_addr_t             addr,
    input  cp0_pkg::word_t                 wdata,
    input  cp0_pkg::word_t                 pc,
    input  logic                           bd,
    input  cp0_pkg::word_t                 bad_vaddr,
    input  logic [5:0]                     ext_int,
    input  logic                           found,
    input  logic [$clog2(TLB_ENTRIES)-1:0] probe_index,
    input  tlb_pkg::vpn2_t                 rd_vpn2,
    input  tlb_pkg::asid_t                 rd_asid,
    input  logic                           rd_g,
    input  tlb_pkg::pfn_t                  rd_pfn0,
    input  tlb_pkg::cattr_t                rd_c0,
    input  logic                           rd_d0,
    input  logic                           rd_v0,
    input  tlb_pkg::pfn_t                  rd_pfn1,
    input  tlb_pkg::cattr_t                rd_c1,
    input  logic                           rd_d1,
    input  logic                           rd_v1,
    output cp0_pkg::word_t                 rdata,
    output logic                           status_ie,
    output logic                           status_exl,
    output logic [7:0]                     status_im,
    output logic [7:0]                     cause_ip,
    output cp0_pkg::word_t                 epc,
    output logic                           timer_int,
    output tlb_pkg::vpn2_t                 entryhi_vpn2,
    output tlb_pkg::asid_t                 entryhi_asid,
    output tlb_pkg::pfn_t                  lo0_pfn,
    output tlb_pkg::cattr_t                lo0_c,
    output logic                           lo0_d,
    output logic                           lo0_v,
    output logic                           lo0_g,
    output tlb_pkg::pfn_t                  lo1_pfn,
    output tlb_pkg::cattr_t                lo1_c,
    output logic                           lo1_d,
    output logic                           lo1_v,
    output logic                           lo1_g,
    output logic [$clog2(TLB_ENTRIES)-1:0] index
);

    import cp0_pkg::*;
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLB_ENTRIES);
    localparam cp0_addr_t LO_ADDR [2] = '{ENTRYLO0_ADDR, ENTRYLO1_ADDR};

    logic      cause_bd;
    logic      cause_ti;
    exc_code_t cause_exc;
    word_t     badvaddr;
    word_t     count;
    word_t     compare;
    logic      tick;         // Halves the Count rate
    logic      index_p;

    // EntryLo0 and EntryLo1 share one update rule
    pfn_t   lo_pfn [2];
    cattr_t lo_c   [2];
    logic   lo_d   [2];
    logic   lo_v   [2];
    logic   lo_g   [2];
    pfn_t   tlb_pfn [2];
    cattr_t tlb_c   [2];
    logic   tlb_d   [2];
    logic   tlb_v   [2];

    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
            status_im  <= '0;
        end else begin
            if (mtc0_we && addr == STATUS_ADDR) begin
                status_ie <= wdata[0];
                status_im <= wdata[15:8];
            end
            if (exc)
                status_exl <= 1'b1;
            else if (eret)
                status_exl <= 1'b0;
            else if (mtc0_we && addr == STATUS_ADDR)
                status_exl <= wdata[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd <= 1'b0;
            cause_ti <= 1'b0;
            cause_ip <= '0;
        end else begin
            if (exc && !status_exl)
                cause_bd <= bd;
            if (mtc0_we && addr == COMPARE_ADDR)
                cause_ti <= 1'b0;
            else if (count == compare)
                cause_ti <= 1'b1;
            cause_ip[7]   <= ext_int[5] | cause_ti;
            cause_ip[6:2] <= ext_int[4:0];
            if (mtc0_we && addr == CAUSE_ADDR)
                cause_ip[1:0] <= wdata[9:8];    // Software interrupts
        end
    end

    assign timer_int = cause_ti;

    always_ff @(posedge clk) begin
        if (exc)
            cause_exc <= exc_code_out;
        if (exc && (exc_code_out == EXC_ADEL || exc_code_out == EXC_ADES))
            badvaddr <= (pc[1:0] != 2'b00) ? pc : bad_vaddr;   // Fetch fault first
        if (exc && !status_exl)
            epc <= bd ? pc - 32'd4 : pc;        // Branch owns the delay slot
        else if (mtc0_we && addr == EPC_ADDR)
            epc <= wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= '0;
            compare <= COMPARE_RESET;
        end else begin
            tick <= ~tick;
            if (mtc0_we && addr == COUNT_ADDR)
                count <= wdata;
            else if (tick)
                count <= count + 32'd1;
            if (mtc0_we && addr == COMPARE_ADDR)
                compare <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (mtc0_we && addr == ENTRYHI_ADDR) begin
            entryhi_vpn2 <= wdata[VPN2_LSB +: $bits(vpn2_t)];
            entryhi_asid <= wdata[ASID_LSB +: $bits(asid_t)];
        end else if (tlbr) begin
            entryhi_vpn2 <= rd_vpn2;
            entryhi_asid <= rd_asid;
        end
    end

    assign tlb_pfn[0] = rd_pfn0;
    assign tlb_c[0]   = rd_c0;
    assign tlb_d[0]   = rd_d0;
    assign tlb_v[0]   = rd_v0;
    assign tlb_pfn[1] = rd_pfn1;
    assign tlb_c[1]   = rd_c1;
    assign tlb_d[1]   = rd_d1;
    assign tlb_v[1]   = rd_v1;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (mtc0_we && addr == LO_ADDR[i]) begin
                lo_pfn[i] <= wdata[PFN_LSB +: $bits(pfn_t)];
                lo_c[i]   <= wdata[C_LSB +: $bits(cattr_t)];
                lo_d[i]   <= wdata[D_BIT];
                lo_v[i]   <= wdata[V_BIT];
                lo_g[i]   <= wdata[G_BIT];
            end else if (tlbr) begin
                lo_pfn[i] <= tlb_pfn[i];
                lo_c[i]   <= tlb_c[i];
                lo_d[i]   <= tlb_d[i];
                lo_v[i]   <= tlb_v[i];
                lo_g[i]   <= rd_g;              // Entry keeps a single G
            end
        end
    end

    assign lo0_pfn = lo_pfn[0];
    assign lo0_c   = lo_c[0];
    assign lo0_d   = lo_d[0];
    assign lo0_v   = lo_v[0];
    assign lo0_g   = lo_g[0];
    assign lo1_pfn = lo_pfn[1];
    assign lo1_c   = lo_c[1];
    assign lo1_d   = lo_d[1];
    assign lo1_v   = lo_v[1];
    assign lo1_g   = lo_g[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            index_p <= 1'b0;
            index   <= '0;
        end else begin
            if (tlbp)
                index_p <= ~found;
            if (mtc0_we && addr == INDEX_ADDR)
                index <= wdata[IDX_W-1:0];
            else if (tlbp && found)
                index <= probe_index;           // Miss leaves Index alone
        end
    end

    always_comb begin
        case (addr)
            INDEX_ADDR:    rdata = {index_p, {(31 - IDX_W){1'b0}}, index};
            ENTRYLO0_ADDR: rdata = {6'b0, lo_pfn[0], lo_c[0], lo_d[0], lo_v[0], lo_g[0]};
            ENTRYLO1_ADDR: rdata = {6'b0, lo_pfn[1], lo_c[1], lo_d[1], lo_v[1], lo_g[1]};
            BADVADDR_ADDR: rdata = badvaddr;
            COUNT_ADDR:    rdata = count;
            ENTRYHI_ADDR:  rdata = {entryhi_vpn2, 5'b0, entryhi_asid};
            COMPARE_ADDR:  rdata = compare;
            STATUS_ADDR:   rdata = {9'b0, 1'b1, 6'b0, status_im, 6'b0, status_exl, status_ie};
            CAUSE_ADDR:    rdata = {cause_bd, cause_ti, 14'b0, cause_ip, 1'b0, cause_exc, 2'b0};
            EPC_ADDR:      rdata = epc;
            default:       rdata = '0;
        endcase
    end

endmodule

/* logic/cp0_commit.sv */
`timescale 1ns/10ps

module cp0_commit (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  cp0_pkg::commit_op_t op,
    input  logic [4:0]          rd,
    input  logic [2:0]          sel,
    input  cp0_pkg::word_t      wdata,
    input  logic                ex,
    input  cp0_pkg::exc_code_t  exc_code,
    input  cp0_pkg::word_t      pc,
    input  logic                bd,
    input  cp0_pkg::word_t      bad_vaddr,
    input  logic                status_ie,
    input  logic                status_exl,
    input  logic [7:0]          status_im,
    input  logic [7:0]          cause_ip,
    input  cp0_pkg::word_t      epc,
    output logic                mtc0_we,
    output logic                eret,
    output logic                exc,
    output cp0_pkg::exc_code_t  exc_code_out,
    output logic                tlbp,
    output logic                tlbr,
    output logic                tlbwi,
    output cp0_pkg::cp0_addr_t  addr,
    output logic                flush,
    output cp0_pkg::word_t      flush_pc,
    output logic                eret_flush,
    output logic                exc_flush
);

    import cp0_pkg::*;

    logic int_pending;
    logic take_int;
    logic commit_act;

    assign int_pending = |(cause_ip & status_im);
    assign take_int    = valid && !ex && status_ie && !status_exl && int_pending;
    assign commit_act  = valid && !ex && !take_int;    // Own action survives

    assign addr         = {rd, sel};
    assign exc          = valid && (ex || take_int);
    assign exc_code_out = take_int ? EXC_INT : exc_code;

    always_comb begin
        mtc0_we = 1'b0;
        eret    = 1'b0;
        tlbp    = 1'b0;
        tlbr    = 1'b0;
        tlbwi   = 1'b0;
        if (commit_act) begin
            case (op)
                OP_MTC0:  mtc0_we = 1'b1;
                OP_ERET:  eret    = 1'b1;
                OP_TLBP:  tlbp    = 1'b1;
                OP_TLBR:  tlbr    = 1'b1;
                OP_TLBWI: tlbwi   = 1'b1;
                default:  ;                 // mfc0 is served by the read mux
            endcase
        end
    end

    // Redirect in the same cycle as the commit
    assign exc_flush  = exc;
    assign eret_flush = eret;
    assign flush      = exc_flush || eret_flush;
    assign flush_pc   = exc_flush ? EXC_VECTOR : epc;

endmodule

/* logic/tlb_pkg.sv */
package tlb_pkg;

    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;

    // Field positions in EntryHi and EntryLo
    localparam int VPN2_LSB = 13;
    localparam int ASID_LSB = 0;
    localparam int PFN_LSB  = 6;
    localparam int C_LSB    = 3;
    localparam int D_BIT    = 2;
    localparam int V_BIT    = 1;
    localparam int G_BIT    = 0;

endpackage

/* logic/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  cp0_addr_t;    // {rd, sel}
    typedef logic [4:0]  exc_code_t;

    // Register addresses, all at sel 0
    localparam cp0_addr_t INDEX_ADDR    = {5'd0, 3'd0};
    localparam cp0_addr_t ENTRYLO0_ADDR = {5'd2, 3'd0};
    localparam cp0_addr_t ENTRYLO1_ADDR = {5'd3, 3'd0};
    localparam cp0_addr_t BADVADDR_ADDR = {5'd8, 3'd0};
    localparam cp0_addr_t COUNT_ADDR    = {5'd9, 3'd0};
    localparam cp0_addr_t ENTRYHI_ADDR  = {5'd10, 3'd0};
    localparam cp0_addr_t COMPARE_ADDR  = {5'd11, 3'd0};
    localparam cp0_addr_t STATUS_ADDR   = {5'd12, 3'd0};
    localparam cp0_addr_t CAUSE_ADDR    = {5'd13, 3'd0};
    localparam cp0_addr_t EPC_ADDR      = {5'd14, 3'd0};

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;     // Load or fetch
    localparam exc_code_t EXC_ADES = 5'd5;     // Store
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_BP   = 5'd9;
    localparam exc_code_t EXC_RI   = 5'd10;
    localparam exc_code_t EXC_OV   = 5'd12;

    // Coprocessor action of the retiring instruction
    typedef enum logic [2:0] {
        OP_NONE,
        OP_MTC0,
        OP_MFC0,
        OP_ERET,
        OP_TLBP,
        OP_TLBR,
        OP_TLBWI
    } commit_op_t;

    localparam word_t EXC_VECTOR    = 32'hBFC0_0380;    // Bev is fixed at 1
    localparam word_t COMPARE_RESET = 32'h0001_55cc;

endpackage
